/* hw/mp_loop_pkg.sv */
package mp_loop_pkg;

	// signed fraction word on every data port
	localparam int W = 18;
	localparam int PROD_W = 2 * W;

	// eight-cycle frame started by sync
	localparam int SLOTS = 8;
	localparam int SLOT_W = 3;
	localparam logic [SLOT_W-1:0] SLOT_MAG = 0;
	localparam logic [SLOT_W-1:0] SLOT_PHA = 1;
	localparam logic [SLOT_W-1:0] SLOT_CALC = 2;
	// first of the four lock comparison slots
	localparam logic [SLOT_W-1:0] SLOT_CMP = 3;
	// timer waits here for the next sync
	localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(SLOTS - 1);

	// output frame layout
	localparam logic [SLOT_W-1:0] OUT_DRV_X = 0;
	localparam logic [SLOT_W-1:0] OUT_DRV_Y = 1;
	localparam logic [SLOT_W-1:0] OUT_SET_X = 2;
	localparam logic [SLOT_W-1:0] OUT_SET_P = 3;
	localparam logic [SLOT_W-1:0] OUT_GAIN = 4;

	// PI arithmetic
	localparam int AXES = 2;
	localparam int ACC_W = 24;
	localparam int KP_SHIFT = 8;
	localparam int KI_SHIFT = 12;
	localparam int P_W = PROD_W - KP_SHIFT;
	localparam int SUM_W = P_W + 1;

	// 2^17 * 2 / 1.64676^2 takes magnitude units to X units
	localparam int SET_SCALE = 96667;
	localparam int SET_SHIFT = 17;

	// one radian as a 17-bit fraction of a revolution
	localparam logic [W-1:0] RADIAN = 20861;
	localparam int THRESH_SHIFT = 9;
	localparam int LEVELS = 4;

endpackage

/* hw/frame_slot_timer.sv */
`timescale 1ns/1ps

module frame_slot_timer (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             sync,
	output logic [mp_loop_pkg::SLOT_W-1:0]   slot,
	output logic                             frame_ok
);
	import mp_loop_pkg::*;

	// set once the last slot has been held a cycle with no sync
	logic parked;
	logic regular;
	logic missing;

	// sync exactly eight cycles after the one before
	assign regular = sync && slot == SLOT_LAST && !parked;
	// the cycle where sync was due passed without one
	assign missing = !sync && slot == SLOT_LAST && !parked;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= SLOT_LAST;
			parked <= 1'b1;
			frame_ok <= 1'b0;
		end else begin
			// restart on sync, otherwise count up and wait at the last slot
			if (sync)
				slot <= '0;
			else if (slot != SLOT_LAST)
				slot <= slot + 1'b1;
			parked <= !sync && slot == SLOT_LAST;
			// early, late or missing sync all drop the flag
			if (regular)
				frame_ok <= 1'b1;
			else if (sync || missing)
				frame_ok <= 1'b0;
		end
	end

	// a regular stream only ever syncs from the last slot
	a_sync_spacing: assert property (@(posedge clk) disable iff (rst)
		sync && frame_ok |-> slot == SLOT_LAST)
		else $error("sync off the frame grid while frame_ok is high");

endmodule

/* hw/sel_gate_fsm.sv */
`timescale 1ns/1ps

module sel_gate_fsm (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [mp_loop_pkg::SLOT_W-1:0]        slot,
	input  logic signed [mp_loop_pkg::W-1:0]      in_mp,
	input  logic signed [mp_loop_pkg::W-1:0]      sel_thresh,
	output logic                                  sel_ok
);
	import mp_loop_pkg::*;

	// input one cycle late so slot 0 sees the magnitude
	logic signed [W-1:0] in_d;
	logic signed [W-1:0] mag_q;
	logic above;
	logic below;

	// phase is meaningless at low amplitude
	assign above = mag_q > sel_thresh;
	// half threshold gives the hysteresis band
	assign below = mag_q < (sel_thresh >>> 1);

	always_ff @(posedge clk) begin
		in_d <= in_mp;
		if (slot == SLOT_MAG)
			mag_q <= in_d;
	end

	// sel_ok is the state bit
	// OFF to ON above threshold and ON to OFF below half
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_ok <= 1'b0;
		end else if (slot == SLOT_PHA) begin
			if (above)
				sel_ok <= 1'b1;
			else if (below)
				sel_ok <= 1'b0;
		end
	end

	// one decision per frame so no chatter
	a_sel_tick: assert property (@(posedge clk) disable iff (rst)
		!$stable(sel_ok) |-> $past(slot) == SLOT_PHA)
		else $error("sel_ok moved outside the slot-1 tick");

endmodule

/* hw/setpoint_slew.sv */
`timescale 1ns/1ps

module setpoint_slew (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [mp_loop_pkg::SLOT_W-1:0]        slot,
	input  logic signed [mp_loop_pkg::W-1:0]      set_mag,
	input  logic                                  set_slew,
	input  logic signed [mp_loop_pkg::W-1:0]      slew_step,
	output logic signed [mp_loop_pkg::W-1:0]      set_live,
	output logic                                  slewing
);
	import mp_loop_pkg::*;

	// one guard bit so the distance cannot wrap
	logic signed [W:0] gap;
	logic signed [W:0] step_ext;
	logic signed [W:0] live_ext;
	logic close;

	assign live_ext = set_live;
	assign step_ext = slew_step;
	assign gap = set_mag - live_ext;
	// within one step, land exactly on the target
	assign close = gap <= step_ext && gap >= -step_ext;
	assign slewing = set_live != set_mag;

	// once per frame
	always_ff @(posedge clk) begin
		if (rst) begin
			set_live <= '0;
		end else if (slot == SLOT_CALC) begin
			if (!set_slew || close)
				set_live <= set_mag;
			else if (gap > 0)
				set_live <= set_live + slew_step;
			else
				set_live <= set_live - slew_step;
		end
	end

	// rate bound seen from outside the limiter
	a_slew_rate: assert property (@(posedge clk) disable iff (rst)
		$past(set_slew) && !$past(rst) |->
			live_ext - $past(live_ext) <= $past(step_ext) &&
			live_ext - $past(live_ext) >= -$past(step_ext))
		else $error("setpoint moved more than slew_step in one frame");

endmodule

/* hw/mp_pi_clip.sv */
`timescale 1ns/1ps

module mp_pi_clip (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [mp_loop_pkg::SLOT_W-1:0]        slot,
	input  logic                                  frame_ok,
	input  logic                                  sel_ok,
	input  logic                                  sel_en,
	input  logic signed [mp_loop_pkg::W-1:0]      in_mp,
	input  logic signed [mp_loop_pkg::W-1:0]      set_live,
	input  logic signed [mp_loop_pkg::W-1:0]      set_pha,
	input  logic signed [mp_loop_pkg::W-1:0]      ph_offset,
	input  logic signed [mp_loop_pkg::W-1:0]      kp,
	input  logic signed [mp_loop_pkg::W-1:0]      ki,
	input  logic signed [mp_loop_pkg::W-1:0]      lim_x,
	input  logic signed [mp_loop_pkg::W-1:0]      lim_y,
	output logic signed [mp_loop_pkg::W-1:0]      err_m,
	output logic signed [mp_loop_pkg::W-1:0]      err_p,
	output logic [3:0]                            clipped,
	output logic                                  out_sync_pre,
	output logic signed [mp_loop_pkg::W-1:0]      out_xy,
	output logic signed [mp_loop_pkg::W-1:0]      out_ph
);
	import mp_loop_pkg::*;

	logic signed [W-1:0] in_d;
	logic signed [W-1:0] mag_q;
	logic signed [W-1:0] pha_q;
	// index 0 is X (magnitude) and index 1 is Y (phase)
	logic signed [W-1:0] err [AXES];
	logic signed [W-1:0] lim [AXES];
	logic signed [PROD_W-1:0] prod_p [AXES];
	logic signed [PROD_W-1:0] prod_i [AXES];
	logic signed [P_W-1:0] p_term [AXES];
	logic signed [ACC_W-1:0] inc [AXES];
	logic signed [ACC_W-1:0] integ [AXES];
	logic signed [SUM_W-1:0] sum [AXES];
	logic signed [W-1:0] drv [AXES];
	logic [AXES-1:0] hi_now;
	logic [AXES-1:0] lo_now;
	logic [AXES-1:0] clip_hi;
	logic [AXES-1:0] clip_lo;
	logic signed [PROD_W-1:0] set_prod;
	logic signed [W-1:0] drv_ph;
	// output frame words held from the end of the frame
	logic signed [W-1:0] word_y;
	logic signed [W-1:0] word_sx;
	logic signed [W-1:0] word_kp;
	logic signed [W-1:0] word_ph;
	logic signed [W-1:0] word_sp;
	logic last_q;
	logic out_live;
	logic [SLOT_W-1:0] out_slot;
	logic [SLOT_W-1:0] next_slot;
	logic xy_used;
	logic ph_used;

	assign err_m = err[0];
	assign err_p = err[1];
	assign lim[0] = lim_x;
	assign lim[1] = lim_y;

	always_comb begin
		for (int i = 0; i < AXES; i++) begin
			prod_p[i] = err[i] * kp;
			prod_i[i] = err[i] * ki;
			// symmetric clamp at plus and minus lim
			hi_now[i] = sum[i] >= lim[i];
			lo_now[i] = sum[i] < -lim[i];
		end
	end

	// capture, error, products, sum and clamp in slot order
	always_ff @(posedge clk) begin
		in_d <= in_mp;
		if (slot == SLOT_MAG)
			mag_q <= in_d;
		if (slot == SLOT_PHA) begin
			pha_q <= in_d;
			// both errors wrap in W bits
			err[0] <= mag_q - set_live;
			err[1] <= in_d - set_pha;
		end
		for (int i = 0; i < AXES; i++) begin
			if (slot == SLOT_CALC) begin
				p_term[i] <= prod_p[i][PROD_W-1:KP_SHIFT];
				inc[i] <= prod_i[i][KI_SHIFT +: ACC_W];
			end
			if (slot == SLOT_CALC + 2)
				sum[i] <= p_term[i] + integ[i];
			if (slot == SLOT_CALC + 3)
				drv[i] <= hi_now[i] ? lim[i] : lo_now[i] ? -lim[i] : sum[i][W-1:0];
		end
	end

	// integrators step at slot 3 using last frame's clip state
	// no history builds up while the amplitude gate is off
	always_ff @(posedge clk) begin
		if (rst || !sel_ok) begin
			for (int i = 0; i < AXES; i++)
				integ[i] <= '0;
		end else if (slot == SLOT_CALC + 1 && frame_ok) begin
			for (int i = 0; i < AXES; i++)
				if (!(clip_hi[i] && inc[i] > 0) && !(clip_lo[i] && inc[i] < 0))
					integ[i] <= integ[i] + inc[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			clip_hi <= '0;
			clip_lo <= '0;
		end else if (slot == SLOT_CALC + 3) begin
			clip_hi <= hi_now;
			clip_lo <= lo_now;
		end
	end

	assign set_prod = set_live * SET_SCALE;
	assign drv_ph = (sel_en && sel_ok) ? pha_q + ph_offset : '0;
	assign next_slot = out_slot + 1'b1;

	always_ff @(posedge clk) begin
		if (last_q) begin
			word_y <= drv[1];
			word_sx <= set_prod[SET_SHIFT +: W];
			word_kp <= kp;
			word_ph <= drv_ph;
			word_sp <= set_pha;
		end
	end

	// output frame starts the cycle after slot 7
	always_ff @(posedge clk) begin
		if (rst) begin
			last_q <= 1'b0;
			out_sync_pre <= 1'b0;
			out_live <= 1'b0;
			out_slot <= '0;
			out_xy <= '0;
			out_ph <= '0;
			clipped <= '0;
		end else begin
			last_q <= slot == SLOT_LAST - 1'b1;
			out_sync_pre <= last_q;
			// event bits move one cycle after out_sync
			if (out_sync_pre)
				clipped <= {clip_lo, clip_hi};
			if (last_q) begin
				out_live <= 1'b1;
				out_slot <= OUT_DRV_X;
				out_xy <= drv[0];
				out_ph <= '0;
			end else if (out_live && out_slot != SLOT_LAST) begin
				out_slot <= next_slot;
				out_xy <= next_slot == OUT_DRV_Y ? word_y :
					next_slot == OUT_SET_X ? word_sx :
					next_slot == OUT_GAIN ? word_kp : '0;
				out_ph <= next_slot == OUT_DRV_Y ? word_ph :
					next_slot == OUT_SET_P ? word_sp : '0;
			end else begin
				out_live <= 1'b0;
				out_xy <= '0;
				out_ph <= '0;
			end
		end
	end

	assign xy_used = out_live && (out_slot == OUT_DRV_X || out_slot == OUT_DRV_Y ||
		out_slot == OUT_SET_X || out_slot == OUT_GAIN);
	assign ph_used = out_live && (out_slot == OUT_DRV_Y || out_slot == OUT_SET_P);

	a_idle_slots: assert property (@(posedge clk) disable iff (rst)
		(!xy_used |-> out_xy == '0) and (!ph_used |-> out_ph == '0))
		else $error("nonzero word in an unused output slot");

endmodule

/* hw/lock_detect.sv */
`timescale 1ns/1ps

module lock_detect (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [mp_loop_pkg::SLOT_W-1:0]        slot,
	input  logic signed [mp_loop_pkg::W-1:0]      err_m,
	input  logic signed [mp_loop_pkg::W-1:0]      err_p,
	input  logic signed [mp_loop_pkg::W-1:0]      set_live,
	output logic [7:0]                            over
);
	import mp_loop_pkg::*;

	logic [W-2:0] abs_m;
	logic [W-2:0] abs_p;
	logic [W-2:0] th_m;
	logic [W-2:0] th_p;
	logic signed [W-1:0] set_sh;
	logic [1:0] level;
	logic [7:0] hits;
	logic done_q;
	logic done_q2;

	// 0.2% of setpoint at the first level with a shift of 9
	assign set_sh = set_live >>> THRESH_SHIFT;
	// slots 3 to 6 give levels 0 to 3
	assign level = 2'(slot - SLOT_CMP);

	always_ff @(posedge clk) begin
		if (slot == SLOT_CALC) begin
			// one's complement so -1 reads as 0
			abs_m <= err_m[W-1] ? ~err_m[W-2:0] : err_m[W-2:0];
			abs_p <= err_p[W-1] ? ~err_p[W-2:0] : err_p[W-2:0];
			th_m <= set_sh[W-2:0];
			// 0.002 rad first phase level
			th_p <= RADIAN[W-2:0] >> THRESH_SHIFT;
		end else begin
			th_m <= th_m >> 1;
			th_p <= th_p >> 1;
		end
		// strictly greater, an error at the threshold does not fire
		if (slot >= SLOT_CMP && slot < SLOT_CMP + LEVELS) begin
			hits[2 * level] <= abs_m > th_m;
			hits[2 * level + 1] <= abs_p > th_p;
		end
	end

	// publish with the clip bits, one cycle after out_sync
	always_ff @(posedge clk) begin
		if (rst) begin
			done_q <= 1'b0;
			done_q2 <= 1'b0;
			over <= '0;
		end else begin
			done_q <= slot == SLOT_LAST - 1'b1;
			done_q2 <= done_q;
			if (done_q2)
				over <= hits;
		end
	end

endmodule

/* hw/mp_loop_proc.sv */
`timescale 1ns/1ps

module mp_loop_proc (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  sync,
	input  logic signed [mp_loop_pkg::W-1:0]      in_mp,
	input  logic                                  sel_en,
	input  logic signed [mp_loop_pkg::W-1:0]      ph_offset,
	input  logic signed [mp_loop_pkg::W-1:0]      sel_thresh,
	input  logic                                  set_slew,
	input  logic signed [mp_loop_pkg::W-1:0]      slew_step,
	input  logic signed [mp_loop_pkg::W-1:0]      set_mag,
	input  logic signed [mp_loop_pkg::W-1:0]      set_pha,
	input  logic signed [mp_loop_pkg::W-1:0]      kp,
	input  logic signed [mp_loop_pkg::W-1:0]      ki,
	input  logic signed [mp_loop_pkg::W-1:0]      lim_x,
	input  logic signed [mp_loop_pkg::W-1:0]      lim_y,
	output logic                                  out_sync,
	output logic signed [mp_loop_pkg::W-1:0]      out_xy,
	output logic signed [mp_loop_pkg::W-1:0]      out_ph,
	output logic [11:0]                           cmp_event,
	output logic                                  frame_ok,
	output logic                                  slewing
);
	import mp_loop_pkg::*;

	logic [SLOT_W-1:0] slot;
	logic sel_ok;
	logic signed [W-1:0] set_live;
	logic signed [W-1:0] err_m;
	logic signed [W-1:0] err_p;

	frame_slot_timer u_timer (
		.clk      (clk),
		.rst      (rst),
		.sync     (sync),
		.slot     (slot),
		.frame_ok (frame_ok)
	);

	sel_gate_fsm u_sel (
		.clk        (clk),
		.rst        (rst),
		.slot       (slot),
		.in_mp      (in_mp),
		.sel_thresh (sel_thresh),
		.sel_ok     (sel_ok)
	);

	setpoint_slew u_slew (
		.clk       (clk),
		.rst       (rst),
		.slot      (slot),
		.set_mag   (set_mag),
		.set_slew  (set_slew),
		.slew_step (slew_step),
		.set_live  (set_live),
		.slewing   (slewing)
	);

	// clip flags are the upper four event bits
	mp_pi_clip u_pi (
		.clk          (clk),
		.rst          (rst),
		.slot         (slot),
		.frame_ok     (frame_ok),
		.sel_ok       (sel_ok),
		.sel_en       (sel_en),
		.in_mp        (in_mp),
		.set_live     (set_live),
		.set_pha      (set_pha),
		.ph_offset    (ph_offset),
		.kp           (kp),
		.ki           (ki),
		.lim_x        (lim_x),
		.lim_y        (lim_y),
		.err_m        (err_m),
		.err_p        (err_p),
		.clipped      (cmp_event[11:8]),
		.out_sync_pre (out_sync),
		.out_xy       (out_xy),
		.out_ph       (out_ph)
	);

	lock_detect u_lock (
		.clk      (clk),
		.rst      (rst),
		.slot     (slot),
		.err_m    (err_m),
		.err_p    (err_p),
		.set_live (set_live),
		.over     (cmp_event[7:0])
	);

endmodule

/* include/tb_mp_loop_table.svh */
// one row per input frame, driven from the sync edge
// columns: skip fok slw noise | mag pha | set_mag slew step ki lim_x sel_en |
//          exp x, y, setpoint x, drive phase, cmp_event
typedef struct {
	int skip;
	int fok;
	int slw;
	int noise;
	int mag;
	int pha;
	int set_mag;
	int slew;
	int step;
	int ki;
	int lim_x;
	int sel_en;
	int x;
	int y;
	int sx;
	int ph;
	int cmp;
} row_t;

localparam int ROWS = 20;

// fixed controls: kp 256, ki 4096 or 0, set_pha 1000, ph_offset 500, sel_thresh 20000
row_t rows [ROWS] = '{
	// first sync, integrator frozen while frame_ok is low
	'{0, 0, 1, 0, 30000, 2000, 51200, 0, 0, 4096, 100000, 1, 30000, 1000, 37760, 2500, 'h0FF},
	'{0, 1, 0, 0, 30000, 2000, 51200, 0, 0, 4096, 100000, 1, -42400, 2000, 37760, 2500, 'h0FF},
	// errors exactly at the first magnitude and third phase level
	'{0, 1, 0, 0, 51300, 1010, 51200, 0, 0, 4096, 100000, 1, -21000, 1020, 37760, 1510, 'h0D4},
	// -1 reads as zero, phase error of 41 reads as 40
	'{0, 1, 0, 0, 51199, 959, 51200, 0, 0, 4096, 100000, 1, -21102, 928, 37760, 1459, 'h0A8},
	// small lim_x, clip then hold then reverse out of the clip
	'{0, 1, 0, 0, 81200, 1000, 51200, 0, 0, 4096, 5000, 1, 5000, 969, 37760, 1500, 'h155},
	'{0, 1, 0, 0, 81200, 1000, 51200, 0, 0, 4096, 5000, 1, 5000, 969, 37760, 1500, 'h155},
	'{0, 1, 0, 0, 49200, 1000, 51200, 0, 0, 4096, 5000, 1, 4899, 969, 37760, 1500, 'h055},
	// inside the hysteresis band, then below half, then sel_en low
	'{0, 1, 0, 0, 15000, 1000, 51200, 0, 0, 4096, 100000, 1, -65501, 969, 37760, 1500, 'h055},
	'{0, 1, 0, 0, 5000, 1000, 51200, 0, 0, 4096, 100000, 1, -46200, 0, 37760, 0, 'h055},
	'{0, 1, 0, 0, 30000, 1300, 51200, 0, 0, 0, 100000, 0, -21200, 300, 37760, 0, 'h0FF},
	// noise frames, stimulus and expectations filled in at run time
	'{0, 1, 0, 1, 0, 0, 51200, 0, 0, 0, 100000, 1, 0, 0, 0, 0, 0},
	'{0, 1, 0, 1, 0, 0, 51200, 0, 0, 0, 100000, 1, 0, 0, 0, 0, 0},
	'{0, 1, 0, 1, 0, 0, 51200, 0, 0, 0, 100000, 1, 0, 0, 0, 0, 0},
	'{0, 1, 0, 1, 0, 0, 51200, 0, 0, 0, 100000, 1, 0, 0, 0, 0, 0},
	// slewed jump of 10000 in steps of 5000, then an unslewed jump back
	'{0, 1, 1, 0, 51200, 1000, 61200, 1, 5000, 0, 100000, 1, 0, 0, 41448, 1500, 'h000},
	'{0, 1, 1, 0, 51200, 1000, 61200, 1, 5000, 0, 100000, 1, -5000, 0, 45135, 1500, 'h055},
	'{0, 1, 1, 0, 51200, 1000, 51200, 0, 0, 0, 100000, 1, -10000, 0, 37760, 1500, 'h055},
	// missing sync drops frame_ok, two regular syncs bring it back
	'{1, 0, 0, 0, 51200, 1000, 51200, 0, 0, 0, 100000, 1, 0, 0, 0, 0, 0},
	'{0, 0, 0, 0, 51200, 1000, 51200, 0, 0, 0, 100000, 1, 0, 0, 37760, 1500, 'h000},
	'{0, 1, 0, 0, 51200, 1000, 51200, 0, 0, 0, 100000, 1, 0, 0, 37760, 1500, 'h000}
};

/* sim/tb_mp_loop.sv */
`timescale 1ns/1ps

module tb_mp_loop;
	import mp_loop_pkg::*;

	localparam int HALF = 10;
	localparam int WAIT_MAX = 64;

	`include "tb_mp_loop_table.svh"

	logic clk;
	logic rst;
	logic sync;
	logic signed [W-1:0] in_mp;
	logic sel_en;
	logic signed [W-1:0] ph_offset;
	logic signed [W-1:0] sel_thresh;
	logic set_slew;
	logic signed [W-1:0] slew_step;
	logic signed [W-1:0] set_mag;
	logic signed [W-1:0] set_pha;
	logic signed [W-1:0] kp;
	logic signed [W-1:0] ki;
	logic signed [W-1:0] lim_x;
	logic signed [W-1:0] lim_y;
	logic out_sync;
	logic signed [W-1:0] out_xy;
	logic signed [W-1:0] out_ph;
	logic [11:0] cmp_event;
	logic frame_ok;
	logic slewing;
	int sync_t [ROWS];

	mp_loop_proc DUT (.*);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic expect_eq(input string what, input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		return v ^ (v << 5);
	endfunction

	// over bits for one's complement magnitude against halving levels
	function automatic int lock_bits(input int em, input int ep, input int thm, input int thp);
		int am;
		int ap;
		int b;
		am = em < 0 ? -em - 1 : em;
		ap = ep < 0 ? -ep - 1 : ep;
		b = 0;
		for (int k = 0; k < 4; k++) begin
			if (am > (thm >> k))
				b |= 1 << (2 * k);
			if (ap > (thp >> k))
				b |= 1 << (2 * k + 1);
		end
		return b;
	endfunction

	// stimulus side
	initial begin
		logic [31:0] seed;
		rst = 1'b1;
		sync = 1'b0;
		in_mp = '0;
		sel_en = 1'b0;
		ph_offset = 18'sd500;
		sel_thresh = 18'sd20000;
		set_slew = 1'b0;
		slew_step = '0;
		set_mag = '0;
		set_pha = 18'sd1000;
		kp = 18'sd256;
		ki = '0;
		lim_x = 18'sd100000;
		lim_y = 18'sd100000;
		// noise frames sit near the setpoints with integrators empty
		seed = 32'h492a_8d9d;
		for (int r = 0; r < ROWS; r++) begin
			if (rows[r].noise != 0) begin
				seed = xorshift(seed);
				rows[r].mag = 51200 + int'(seed & 32'h3ff) - 512;
				rows[r].pha = 1000 + int'((seed >> 10) & 32'h7f) - 64;
			end
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// quiet outputs until the first sync
		repeat (10) begin
			@(negedge clk);
			expect_eq("idle out_sync", out_sync, 0);
			expect_eq("idle out_xy", out_xy, 0);
			expect_eq("idle out_ph", out_ph, 0);
			expect_eq("idle cmp_event", cmp_event, 0);
			expect_eq("idle frame_ok", frame_ok, 0);
		end
		for (int r = 0; r < ROWS; r++) begin
			@(posedge clk);
			sync_t[r] = int'($time) + HALF;
			sync <= rows[r].skip == 0;
			in_mp <= 18'(rows[r].mag);
			@(posedge clk);
			sync <= 1'b0;
			in_mp <= 18'(rows[r].pha);
			set_mag <= 18'(rows[r].set_mag);
			set_slew <= rows[r].slew != 0;
			slew_step <= 18'(rows[r].step);
			ki <= 18'(rows[r].ki);
			lim_x <= 18'(rows[r].lim_x);
			sel_en <= rows[r].sel_en != 0;
			@(negedge clk);
			expect_eq($sformatf("frame_ok row %0d", r), frame_ok, rows[r].fok);
			expect_eq($sformatf("slewing row %0d", r), slewing, rows[r].slw);
			repeat (6) begin
				@(posedge clk);
				in_mp <= '0;
			end
		end
	end

	// response side, one output frame per row that had a sync
	initial begin
		int n;
		int exp_xy [SLOTS];
		int exp_ph [SLOTS];
		int exp_cmp;
		@(negedge clk);
		for (int r = 0; r < ROWS; r++) begin
			if (rows[r].skip == 0) begin
				n = 0;
				while (out_sync !== 1'b1 && n < WAIT_MAX) begin
					@(negedge clk);
					n++;
				end
				if (out_sync !== 1'b1)
					stop_run($sformatf("timed out waiting for out_sync of row %0d", r));
				expect_eq("out_sync delay", int'($time) - sync_t[r], 9 * 2 * HALF);
				exp_xy = '{default: 0};
				exp_ph = '{default: 0};
				if (rows[r].noise != 0) begin
					exp_xy[0] = rows[r].mag - 51200;
					exp_xy[1] = rows[r].pha - 1000;
					exp_xy[2] = 37760;
					exp_ph[1] = rows[r].pha + 500;
					exp_cmp = lock_bits(exp_xy[0], exp_xy[1], 51200 >> 9, 20861 >> 9);
				end else begin
					exp_xy[0] = rows[r].x;
					exp_xy[1] = rows[r].y;
					exp_xy[2] = rows[r].sx;
					exp_ph[1] = rows[r].ph;
					exp_cmp = rows[r].cmp;
				end
				exp_xy[4] = 256;
				exp_ph[3] = 1000;
				for (int s = 0; s < SLOTS; s++) begin
					if (s > 0)
						@(negedge clk);
					expect_eq($sformatf("row %0d out_xy slot %0d", r, s), out_xy, exp_xy[s]);
					expect_eq($sformatf("row %0d out_ph slot %0d", r, s), out_ph, exp_ph[s]);
					// event word settles one cycle after out_sync
					if (s == 1)
						expect_eq($sformatf("row %0d cmp_event", r), cmp_event, exp_cmp);
				end
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* mp_loop.f */
+incdir+include
hw/mp_loop_pkg.sv
hw/frame_slot_timer.sv
hw/sel_gate_fsm.sv
hw/setpoint_slew.sv
hw/mp_pi_clip.sv
hw/lock_detect.sv
hw/mp_loop_proc.sv
sim/tb_mp_loop.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mp_loop
RTL_TOP ?= mp_loop_proc
FILELIST ?= mp_loop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
